/* multiplier.f */
mult_pkg.sv
mult_sequencer.sv
mult_leaf_stage.sv
mult_combine_stage.sv
multiplier_top.sv
tb_multiplier.sv

/* tb_multiplier.sv */
`timescale 1ns/100ps

module tb_multiplier
  import mult_pkg::*;
;

  // worst case is about 40 operations of roughly 15 cycles each, plus margin
  localparam int max_cycles = 2000;
  localparam int start_edges = 5;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 start;
  logic                 new_instruction;
  logic [operand_w-1:0] rs1;
  logic [operand_w-1:0] rs2;
  logic [31:0]          rd_low;
  logic [31:0]          rd_high;
  logic                 done;

  // run bookkeeping
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          prop_errors = 0;
  int          tests_run = 0;
  int          tests_passed = 0;
  logic [31:0] lfsr = 32'hacc44c01;
  logic [63:0] last_expected = '0;

  multiplier_top u_multiplier_top (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .new_instruction (new_instruction),
    .rs1             (rs1),
    .rs2             (rs2),
    .rd_low          (rd_low),
    .rd_high         (rd_high),
    .done            (done)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // a finished result stays put until a restart
  hold_result: assert property (@(posedge clk) disable iff (rst)
                                done |=> $stable({rd_high, rd_low}))
    else begin
      $display("** Error at %0t ns: result moved while done was high", $time);
      prop_errors++;
    end

  // new_instruction always masks done
  done_masked: assert property (@(posedge clk) disable iff (rst) new_instruction |-> !done)
    else begin
      $display("** Error at %0t ns: done high together with new_instruction", $time);
      prop_errors++;
    end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic logic random_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
    return lfsr[0];
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < 32; i++) begin
      r = {r[30:0], random_bit()};
    end
    return r;
  endfunction

  function automatic int total_errors();
    return errors + prop_errors;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    assert (got === exp)
      else begin
        $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        errors++;
      end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    assert (got === exp)
      else begin
        $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        errors++;
      end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (total_errors() == errors_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, total_errors() - errors_before);
    end
  endtask

  // one multiply from st_leaf to st_done
  // done must appear exactly after the fifth edge with start high
  task automatic multiply_op(input logic [31:0] a, input logic [31:0] b,
                             input bit pauses, input bit scramble);
    logic [63:0] expected;
    int          high_edges;
    expected   = {32'd0, a} * {32'd0, b};
    high_edges = 0;
    @(posedge clk);
    rs1   <= a;
    rs2   <= b;
    start <= 1'b1;
    while (high_edges < start_edges) begin
      @(posedge clk);
      // start as the DUT saw it on this edge
      if (start) begin
        high_edges++;
      end
      // operands are captured on the first high edge, later values are noise
      if (scramble && high_edges > 0) begin
        rs1 <= random_word();
        rs2 <= random_word();
      end
      if (pauses && high_edges < start_edges) begin
        // low about one cycle in four
        start <= random_bit() | random_bit();
      end else begin
        start <= 1'b1;
      end
      @(negedge clk);
      check_bit(done, high_edges == start_edges, "done");
    end
    check_value({rd_high, rd_low}, expected, "product");
    last_expected = expected;
  endtask

  // hold in done, then raise new_instruction, wait ni_wait cycles with start low,
  // and clear on the next start-high edge
  task automatic restart_op(input int hold_cycles, input int ni_wait);
    for (int i = 0; i < hold_cycles; i++) begin
      @(posedge clk);
      start <= random_bit();
      @(negedge clk);
      check_bit(done, 1'b1, "done while holding");
      check_value({rd_high, rd_low}, last_expected, "held product");
    end
    @(posedge clk);
    new_instruction <= 1'b1;
    start           <= (ni_wait == 0);
    @(negedge clk);
    // done drops in the same cycle
    check_bit(done, 1'b0, "done with new_instruction high");
    for (int i = 0; i < ni_wait; i++) begin
      @(posedge clk);
      start <= (i == ni_wait - 1);
      @(negedge clk);
      check_bit(done, 1'b0, "done waiting for start");
      check_value({rd_high, rd_low}, last_expected, "product before clear edge");
    end
    @(posedge clk);
    start           <= 1'b0;
    new_instruction <= 1'b0;
    @(negedge clk);
    check_bit(done, 1'b0, "done after restart");
    check_value({rd_high, rd_low}, 64'd0, "result after restart");
  endtask

  initial begin
    int base;
    rst             = 1'b1;
    start           = 1'b0;
    new_instruction = 1'b0;
    rs1             = '0;
    rs2             = '0;

    // reset
    base = total_errors();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_bit(done, 1'b0, "done after reset");
    check_value({rd_high, rd_low}, 64'd0, "result after reset");
    end_test("reset", base);

    // corner operands
    base = total_errors();
    multiply_op(32'h0000_0000, 32'h89ab_cdef, 1'b0, 1'b0);
    restart_op(2, 0);
    multiply_op(32'h0000_0001, 32'h89ab_cdef, 1'b0, 1'b0);
    restart_op(2, 0);
    multiply_op(32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0);
    restart_op(2, 0);
    multiply_op(32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0);
    restart_op(2, 0);
    end_test("corners", base);

    // random operands
    base = total_errors();
    for (int i = 0; i < 25; i++) begin
      multiply_op(random_word(), random_word(), 1'b0, 1'b0);
      restart_op(2, 0);
    end
    end_test("random", base);

    // start dropped for random gaps
    base = total_errors();
    for (int i = 0; i < 6; i++) begin
      multiply_op(random_word(), random_word(), 1'b1, 1'b0);
      restart_op(2, 0);
    end
    end_test("paused_start", base);

    // long holds, and new_instruction waiting on start
    base = total_errors();
    multiply_op(random_word(), random_word(), 1'b0, 1'b0);
    restart_op(20, 0);
    multiply_op(random_word(), random_word(), 1'b0, 1'b0);
    restart_op(5, 3);
    end_test("restart", base);

    // operands change after capture
    base = total_errors();
    for (int i = 0; i < 4; i++) begin
      multiply_op(random_word(), random_word(), i[0], 1'b1);
      restart_op(2, 0);
    end
    end_test("operand_capture", base);

    $display("tests: %0d run, %0d passed, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_passed, tests_run - tests_passed, checks, total_errors());
    if (total_errors() == 0 && tests_passed == tests_run) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* multiplier_top.sv */
`timescale 1ns/100ps

module multiplier_top
  import mult_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic                 new_instruction,
  input  logic [operand_w-1:0] rs1,
  input  logic [operand_w-1:0] rs2,
  output logic [31:0]          rd_low,
  output logic [31:0]          rd_high,
  output logic                 done
);

  // load strobes shared by every stage
  stage_en_t stage_en;

  // partial products between the levels
  leaf_prod_t           leaf_prod;
  byte_prod_t           byte_prod;
  half_prod_t           half_prod;
  word_prod_t           word_prod;
  logic [product_w-1:0] dword_prod;

  // level counter, one level per cycle with start high
  mult_sequencer u_sequencer (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .new_instruction (new_instruction),
    .stage_en        (stage_en),
    .done            (done)
  );

  // operand split and 2x2 digit products
  mult_leaf_stage u_leaf (
    .clk       (clk),
    .rs1       (rs1),
    .rs2       (rs2),
    .load      (stage_en.leaf_en),
    .leaf_prod (leaf_prod)
  );

  // each intermediate level is loaded the cycle before the next level reads it
  // 256 x 4-bit into 64 x 8-bit
  mult_combine_stage #(
    .in_w  (leaf_w),
    .n_out (n_byte)
  ) u_byte (
    .clk       (clk),
    .rst       (1'b0),
    .load      (stage_en.byte_en),
    .clear     (1'b0),
    .parts_in  (leaf_prod),
    .parts_out (byte_prod)
  );

  // 64 x 8-bit into 16 x 16-bit
  mult_combine_stage #(
    .in_w  (byte_w),
    .n_out (n_half)
  ) u_half (
    .clk       (clk),
    .rst       (1'b0),
    .load      (stage_en.half_en),
    .clear     (1'b0),
    .parts_in  (byte_prod),
    .parts_out (half_prod)
  );

  // 16 x 16-bit into 4 x 32-bit
  mult_combine_stage #(
    .in_w  (half_w),
    .n_out (n_word)
  ) u_word (
    .clk       (clk),
    .rst       (1'b0),
    .load      (stage_en.word_en),
    .clear     (1'b0),
    .parts_in  (half_prod),
    .parts_out (word_prod)
  );

  // 4 x 32-bit into the final 64-bit product
  // reset and restart both zero the result
  mult_combine_stage #(
    .in_w  (word_w),
    .n_out (1)
  ) u_dword (
    .clk       (clk),
    .rst       (rst),
    .load      (stage_en.dword_en),
    .clear     (stage_en.clear),
    .parts_in  (word_prod),
    .parts_out (dword_prod)
  );

  // result halves
  assign rd_low  = dword_prod[operand_w-1:0];
  assign rd_high = dword_prod[product_w-1:operand_w];

endmodule

/* mult_combine_stage.sv */
`timescale 1ns/100ps

module mult_combine_stage
  import mult_pkg::*;
#(
  parameter int in_w  = 4,
  parameter int n_out = 64
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                load,
  input  logic                                clear,
  input  logic [n_split*n_out-1:0][in_w-1:0]  parts_in,
  output logic [n_out-1:0][2*in_w-1:0]        parts_out
);

  // combined products before the register
  logic [n_out-1:0][2*in_w-1:0] sum_next;

  // one group of four partial products per output
  // each partial is a product of two in_w/2-bit pieces
  for (genvar g = 0; g < n_out; g++) begin : g_group
    logic [2*in_w-1:0] low_term;
    logic [2*in_w-1:0] cross_term;
    logic [2*in_w-1:0] high_term;

    // lo_a*lo_b at weight 1
    assign low_term = {{in_w{1'b0}}, parts_in[n_split * g]};

    // lo_a*hi_b and hi_a*lo_b share weight 2^(in_w/2)
    // summed first, the carry stays inside 2*in_w bits
    assign cross_term = ({{in_w{1'b0}}, parts_in[n_split * g + 1]}
                       + {{in_w{1'b0}}, parts_in[n_split * g + 2]}) << (in_w / 2);

    // hi_a*hi_b at weight 2^in_w
    assign high_term = {parts_in[n_split * g + 3], {in_w{1'b0}}};

    // true product of the two in_w-bit pieces, cannot overflow
    assign sum_next[g] = low_term + cross_term + high_term;
  end

  // level register
  // clear only matters on the last level, where the result is held
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      parts_out <= '0;
    end else if (load) begin
      parts_out <= sum_next;
    end
  end

endmodule

/* mult_leaf_stage.sv */
`timescale 1ns/100ps

module mult_leaf_stage
  import mult_pkg::*;
(
  input  logic                 clk,
  input  logic [operand_w-1:0] rs1,
  input  logic [operand_w-1:0] rs2,
  input  logic                 load,
  output leaf_prod_t           leaf_prod
);

  // operand pieces at each split level
  // pair k at one level feeds pairs 4k to 4k+3 at the next
  logic [n_word-1:0][operand_w/2-1:0] a_p16;
  logic [n_word-1:0][operand_w/2-1:0] b_p16;
  logic [n_half-1:0][operand_w/4-1:0] a_p8;
  logic [n_half-1:0][operand_w/4-1:0] b_p8;
  logic [n_byte-1:0][operand_w/8-1:0] a_p4;
  logic [n_byte-1:0][operand_w/8-1:0] b_p4;
  logic [n_leaf-1:0][digit_w-1:0]     a_dig;
  logic [n_leaf-1:0][digit_w-1:0]     b_dig;

  // 2x2 products before the register
  leaf_prod_t leaf_next;

  // entry e takes the high half of a when e is 2 or 3,
  // and the high half of b when e is odd

  // whole operands into 16-bit halves
  for (genvar e = 0; e < n_split; e++) begin : g_split_word
    assign a_p16[e] = rs1[(e / 2) * (operand_w / 2) +: operand_w / 2];
    assign b_p16[e] = rs2[(e % 2) * (operand_w / 2) +: operand_w / 2];
  end

  // 16-bit halves into bytes
  for (genvar p = 0; p < n_word; p++) begin : g_split_half
    for (genvar e = 0; e < n_split; e++) begin : g_entry
      assign a_p8[n_split * p + e] = a_p16[p][(e / 2) * (operand_w / 4) +: operand_w / 4];
      assign b_p8[n_split * p + e] = b_p16[p][(e % 2) * (operand_w / 4) +: operand_w / 4];
    end
  end

  // bytes into nibbles
  for (genvar p = 0; p < n_half; p++) begin : g_split_byte
    for (genvar e = 0; e < n_split; e++) begin : g_entry
      assign a_p4[n_split * p + e] = a_p8[p][(e / 2) * (operand_w / 8) +: operand_w / 8];
      assign b_p4[n_split * p + e] = b_p8[p][(e % 2) * (operand_w / 8) +: operand_w / 8];
    end
  end

  // nibbles into 2-bit digits
  for (genvar p = 0; p < n_byte; p++) begin : g_split_nibble
    for (genvar e = 0; e < n_split; e++) begin : g_entry
      assign a_dig[n_split * p + e] = a_p4[p][(e / 2) * digit_w +: digit_w];
      assign b_dig[n_split * p + e] = b_p4[p][(e % 2) * digit_w +: digit_w];
    end
  end

  // digit products from bit ANDs
  // a0b0 at weight 1, the cross terms at weight 2, a1b1 at weight 4
  // largest value is 3*3 = 9, fits in leaf_w bits
  for (genvar n = 0; n < n_leaf; n++) begin : g_digit_mul
    assign leaf_next[n] = {3'b000, a_dig[n][0] & b_dig[n][0]}
                        + {2'b00, a_dig[n][0] & b_dig[n][1], 1'b0}
                        + {2'b00, a_dig[n][1] & b_dig[n][0], 1'b0}
                        + {1'b0, a_dig[n][1] & b_dig[n][1], 2'b00};
  end

  // operands are sampled only here, later changes on rs1/rs2 are ignored
  always_ff @(posedge clk) begin
    if (load) begin
      leaf_prod <= leaf_next;
    end
  end

endmodule

/* mult_sequencer.sv */
`timescale 1ns/100ps

module mult_sequencer
  import mult_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      start,
  input  logic      new_instruction,
  output stage_en_t stage_en,
  output logic      done
);

  // current tree level being loaded
  mult_state_t state;
  mult_state_t state_next;

  // next state and load strobes
  // start low freezes the whole datapath, nothing loads and the state holds
  always_comb begin
    stage_en   = '0;
    state_next = state;
    if (start) begin
      case (state)
        st_leaf: begin
          // capture operands and form all 2x2 products
          stage_en.leaf_en = 1'b1;
          state_next       = st_byte;
        end
        st_byte: begin
          stage_en.byte_en = 1'b1;
          state_next       = st_half;
        end
        st_half: begin
          stage_en.half_en = 1'b1;
          state_next       = st_word;
        end
        st_word: begin
          stage_en.word_en = 1'b1;
          state_next       = st_dword;
        end
        st_dword: begin
          // last level, full 64-bit product lands on this edge
          stage_en.dword_en = 1'b1;
          state_next        = st_done;
        end
        st_done: begin
          // hold the result until a new instruction arrives
          if (new_instruction) begin
            stage_en.clear = 1'b1;
            state_next     = st_leaf;
          end
        end
        default: begin
          // unused encodings fall back to the start of the sequence
          state_next = st_leaf;
        end
      endcase
    end
  end

  // state register
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_leaf;
    end else begin
      state <= state_next;
    end
  end

  // done is a level, not a pulse
  // drops in the same cycle new_instruction goes high
  assign done = (state == st_done) && !new_instruction;

endmodule

/* mult_pkg.sv */
package mult_pkg;

  // operand and full product widths
  localparam int operand_w = 32;
  localparam int product_w = 2 * operand_w;

  // smallest operand piece, two bits of each operand
  localparam int digit_w = 2;

  // every level splits a pair of operands four ways:
  // lo*lo, lo*hi, hi*lo, hi*hi
  localparam int n_split = 4;

  // product widths at each level of the tree
  localparam int leaf_w = 2 * digit_w;
  localparam int byte_w = 2 * leaf_w;
  localparam int half_w = 2 * byte_w;
  localparam int word_w = 2 * half_w;

  // partial product counts per level
  // the word level has one group of four, each level below has four times more
  localparam int n_word = n_split;
  localparam int n_half = n_word * n_split;
  localparam int n_byte = n_half * n_split;
  localparam int n_leaf = n_byte * n_split;

  // partial product arrays
  // group g covers entries 4g to 4g+3, in the order
  // lo_a*lo_b, lo_a*hi_b, hi_a*lo_b, hi_a*hi_b

  // 256 products of two 2-bit digits
  typedef logic [n_leaf-1:0][leaf_w-1:0] leaf_prod_t;

  // 64 products of two 4-bit nibbles
  typedef logic [n_byte-1:0][byte_w-1:0] byte_prod_t;

  // 16 products of two bytes
  typedef logic [n_half-1:0][half_w-1:0] half_prod_t;

  // 4 products of two 16-bit halves
  typedef logic [n_word-1:0][word_w-1:0] word_prod_t;

  // sequencer states, one per tree level plus the final hold state
  typedef enum logic [2:0] {
    st_leaf,
    st_byte,
    st_half,
    st_word,
    st_dword,
    st_done
  } mult_state_t;

  // per-stage load strobes from the sequencer
  // at most one of the *_en bits is high in a cycle
  typedef struct packed {
    logic leaf_en;
    logic byte_en;
    logic half_en;
    logic word_en;
    logic dword_en;
    // zeroes the final product on a restart
    logic clear;
  } stage_en_t;

endpackage
